/* logic/l2c_geom_pkg.sv */
`default_nettype none

package l2c_geom_pkg;

  localparam int NUM_SETS       = 64;
  localparam int NUM_WAYS       = 4;
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_W         = 32;

  typedef logic [$clog2(NUM_SETS)-1:0]       index_t;
  typedef logic [7:0]                        tag_t;
  typedef logic [$clog2(WORDS_PER_LINE)-1:0] offset_t;
  typedef logic [15:0]                       addr_t;   // tag, index, offset
  typedef logic [$clog2(NUM_WAYS)-1:0]       way_t;
  typedef logic [1:0]                        age_t;    // 0 is newest
  typedef logic [WORD_W-1:0]                 word_t;
  typedef logic [WORD_W/8-1:0]               byte_en_t;
  typedef logic [WORDS_PER_LINE*WORD_W-1:0]  line_t;   // word n in lane n

  function automatic tag_t addr_tag(addr_t a);
    return a[$bits(offset_t)+$bits(index_t) +: $bits(tag_t)];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[$bits(offset_t) +: $bits(index_t)];
  endfunction

  function automatic offset_t addr_offset(addr_t a);
    return a[$bits(offset_t)-1:0];
  endfunction

endpackage

`default_nettype wire

/* logic/l2c_txn_pkg.sv */
`default_nettype none

package l2c_txn_pkg;

  // request kinds seen by the cache
  typedef enum logic [1:0] {
    op_read   = 2'd0,
    op_write  = 2'd1,
    op_insert = 2'd2
  } l2c_op_e;

  // credits held by either side of the port
  typedef logic [3:0] credit_t;

endpackage

`default_nettype wire

/* logic/l2c_ifs.sv */
`timescale 1ns/1ns
`default_nettype none

// issued request, queue to tag stage
interface l2c_req_if;
  import l2c_geom_pkg::*;
  import l2c_txn_pkg::*;

  logic     valid;
  l2c_op_e  op;
  addr_t    addr;
  line_t    wdata;
  byte_en_t byte_en;

  modport src (output valid, op, addr, wdata, byte_en);
  modport snk (input valid, op, addr, wdata, byte_en);
endinterface

// resolved access, tag stage to data banks
interface l2c_access_if;
  import l2c_geom_pkg::*;
  import l2c_txn_pkg::*;

  logic     valid;
  l2c_op_e  op;
  logic     hit;
  way_t     way;
  index_t   index;
  offset_t  offset;
  line_t    wdata;
  byte_en_t byte_en;

  modport src (output valid, op, hit, way, index, offset, wdata, byte_en);
  modport snk (input valid, op, hit, way, index, offset, wdata, byte_en);
endinterface

// result, data banks to response side
interface l2c_result_if;
  import l2c_geom_pkg::*;
  import l2c_txn_pkg::*;

  logic    valid;
  l2c_op_e op;
  logic    hit;
  word_t   rdata;

  modport src (output valid, op, hit, rdata);
  modport snk (input valid, op, hit, rdata);
endinterface

`default_nettype wire

/* logic/l2c_req_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_req_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid,
  input  l2c_txn_pkg::l2c_op_e     req_op,
  input  l2c_geom_pkg::addr_t      req_addr,
  input  l2c_geom_pkg::line_t      req_wdata,
  input  l2c_geom_pkg::byte_en_t   req_byte_en,
  input  logic                     ready,
  input  logic                     issue_ok,
  output logic                     req_credit,
  l2c_req_if.src                   req
);
  import l2c_geom_pkg::*;
  import l2c_txn_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

  typedef logic [PTR_W-1:0]                   ptr_t;
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0]   count_t;

  l2c_op_e  op_q      [QUEUE_DEPTH];
  addr_t    addr_q    [QUEUE_DEPTH];
  line_t    wdata_q   [QUEUE_DEPTH];
  byte_en_t byte_en_q [QUEUE_DEPTH];

  ptr_t   wr_ptr;
  ptr_t   rd_ptr;
  count_t count;
  logic   pop;

  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  // head leaves only once the tags are swept and a response slot is free
  assign pop        = (count != '0) && ready && issue_ok;
  assign req_credit = pop;

  assign req.valid   = pop;
  assign req.op      = op_q[rd_ptr];
  assign req.addr    = addr_q[rd_ptr];
  assign req.wdata   = wdata_q[rd_ptr];
  assign req.byte_en = byte_en_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_valid) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      count <= count + count_t'(req_valid) - count_t'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin  // requester only sends with a credit in hand
      op_q[wr_ptr]      <= req_op;
      addr_q[wr_ptr]    <= req_addr;
      wdata_q[wr_ptr]   <= req_wdata;
      byte_en_q[wr_ptr] <= req_byte_en;
    end
  end

endmodule

`default_nettype wire

/* logic/l2c_tag_lru.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_tag_lru (
  input  logic          clk,
  input  logic          rst,
  l2c_req_if.snk        req,
  output logic          ready,
  l2c_access_if.src     acc
);
  import l2c_geom_pkg::*;
  import l2c_txn_pkg::*;

  typedef enum logic {
    init_sweep,
    running
  } state_e;

  state_e state;
  index_t sweep_idx;

  tag_t [NUM_WAYS-1:0] tag_arr [NUM_SETS];
  logic [NUM_WAYS-1:0] vld_arr [NUM_SETS];
  age_t [NUM_WAYS-1:0] age_arr [NUM_SETS];

  // second stage, arrays already read
  logic     s2_valid;
  l2c_op_e  s2_op;
  tag_t     s2_tag;
  index_t   s2_index;
  offset_t  s2_offset;
  line_t    s2_wdata;
  byte_en_t s2_byte_en;
  tag_t [NUM_WAYS-1:0] s2_tags;
  logic [NUM_WAYS-1:0] s2_vld;
  age_t [NUM_WAYS-1:0] s2_ages;

  logic [NUM_WAYS-1:0] match;
  logic                hit;
  way_t                hit_way;
  way_t                victim;
  way_t                way;
  logic                update;
  tag_t [NUM_WAYS-1:0] new_tags;
  logic [NUM_WAYS-1:0] new_vld;
  age_t [NUM_WAYS-1:0] new_ages;
  age_t [NUM_WAYS-1:0] way_order;

  assign ready = (state == running);

  always_comb begin
    match   = '0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (s2_vld[w] && s2_tags[w] == s2_tag) begin
        match[w] = 1'b1;
        hit_way  = way_t'(w);
      end
    end
  end

  assign hit = |match;

  // lowest invalid way first, else the oldest one
  always_comb begin
    victim = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (s2_ages[w] == age_t'(NUM_WAYS - 1)) victim = way_t'(w);
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!s2_vld[w]) victim = way_t'(w);
    end
  end

  assign way    = hit ? hit_way : victim;
  assign update = s2_valid && (hit || s2_op == op_insert);  // misses leave the set alone

  always_comb begin
    new_tags = s2_tags;
    new_vld  = s2_vld;
    new_ages = s2_ages;
    if (update) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (s2_ages[w] < s2_ages[way]) new_ages[w] = s2_ages[w] + age_t'(1);
      end
      new_ages[way] = '0;
      if (s2_op == op_insert) begin
        new_tags[way] = s2_tag;
        new_vld[way]  = 1'b1;
      end
    end
  end

  // swept sets restart with ages in way order, so they stay a permutation
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) way_order[w] = age_t'(w);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= init_sweep;
      sweep_idx <= '0;
      s2_valid  <= 1'b0;
    end else begin
      s2_valid <= req.valid;
      case (state)
        init_sweep: begin
          sweep_idx <= sweep_idx + index_t'(1);
          if (sweep_idx == index_t'(NUM_SETS - 1)) state <= running;
        end
        default: state <= running;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == init_sweep) begin
      vld_arr[sweep_idx] <= '0;
      age_arr[sweep_idx] <= way_order;
    end else if (update) begin
      tag_arr[s2_index] <= new_tags;
      vld_arr[s2_index] <= new_vld;
      age_arr[s2_index] <= new_ages;
    end
  end

  always_ff @(posedge clk) begin
    s2_op      <= req.op;
    s2_tag     <= addr_tag(req.addr);
    s2_index   <= addr_index(req.addr);
    s2_offset  <= addr_offset(req.addr);
    s2_wdata   <= req.wdata;
    s2_byte_en <= req.byte_en;
    if (s2_valid && s2_index == addr_index(req.addr)) begin  // same set, take update
      s2_tags <= new_tags;
      s2_vld  <= new_vld;
      s2_ages <= new_ages;
    end else begin
      s2_tags <= tag_arr[addr_index(req.addr)];
      s2_vld  <= vld_arr[addr_index(req.addr)];
      s2_ages <= age_arr[addr_index(req.addr)];
    end
  end

  assign acc.valid   = s2_valid;
  assign acc.op      = s2_op;
  assign acc.hit     = hit;
  assign acc.way     = way;
  assign acc.index   = s2_index;
  assign acc.offset  = s2_offset;
  assign acc.wdata   = s2_wdata;
  assign acc.byte_en = s2_byte_en;

endmodule

`default_nettype wire

/* logic/l2c_data_banks.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_data_banks (
  input  logic          clk,
  l2c_access_if.snk     acc,
  l2c_result_if.src     res
);
  import l2c_geom_pkg::*;
  import l2c_txn_pkg::*;

  typedef logic [$bits(way_t)+$bits(index_t)-1:0] row_t;

  localparam int ROWS = 2 ** $bits(row_t);

  word_t    mem [WORDS_PER_LINE][ROWS];  // one bank per offset
  row_t     row;
  logic     [WORDS_PER_LINE-1:0] bank_we;
  byte_en_t bank_be;
  logic     rd_en;
  word_t    rd_word;

  assign row     = {acc.way, acc.index};
  assign bank_be = (acc.op == op_insert) ? '1 : acc.byte_en;

  always_comb begin
    for (int b = 0; b < WORDS_PER_LINE; b++) begin
      bank_we[b] = acc.valid &&
                   (acc.op == op_insert ||
                    (acc.op == op_write && acc.hit && acc.offset == offset_t'(b)));
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < WORDS_PER_LINE; b++) begin
      for (int i = 0; i < $bits(byte_en_t); i++) begin
        if (bank_we[b] && bank_be[i]) begin
          mem[b][row][8*i +: 8] <= acc.wdata[b*$bits(word_t) + 8*i +: 8];
        end
      end
    end
    rd_word <= mem[acc.offset][row];
  end

  always_ff @(posedge clk) begin
    res.valid <= acc.valid;
    res.op    <= acc.op;
    res.hit   <= acc.hit;
    rd_en     <= acc.valid && acc.op == op_read && acc.hit;
  end

  assign res.rdata = rd_en ? rd_word : '0;  // zero on misses and non-reads

endmodule

`default_nettype wire

/* logic/l2c_rsp_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_rsp_stage #(
  parameter int RSP_CREDITS = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rsp_credit,
  l2c_result_if.snk              res,
  input  logic                   issue,
  output logic                   issue_ok,
  output logic                   rsp_valid,
  output l2c_txn_pkg::l2c_op_e   rsp_op,
  output logic                   rsp_hit,
  output l2c_geom_pkg::word_t    rsp_rdata
);
  import l2c_txn_pkg::*;

  credit_t credits;

  // a credit is taken at issue, so a response always has a slot
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= credit_t'(RSP_CREDITS);
    end else begin
      credits <= credits - credit_t'(issue) + credit_t'(rsp_credit);
    end
  end

  assign issue_ok = (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= res.valid;
    end
  end

  always_ff @(posedge clk) begin
    rsp_op    <= res.op;
    rsp_hit   <= res.hit;
    rsp_rdata <= res.rdata;
  end

endmodule

`default_nettype wire

/* logic/l2c_top.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_top #(
  parameter int QUEUE_DEPTH = 4,
  parameter int RSP_CREDITS = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid,
  input  l2c_txn_pkg::l2c_op_e     req_op,
  input  l2c_geom_pkg::addr_t      req_addr,
  input  l2c_geom_pkg::line_t      req_wdata,
  input  l2c_geom_pkg::byte_en_t   req_byte_en,
  output logic                     req_credit,
  input  logic                     rsp_credit,
  output logic                     rsp_valid,
  output l2c_txn_pkg::l2c_op_e     rsp_op,
  output logic                     rsp_hit,
  output l2c_geom_pkg::word_t      rsp_rdata
);

  logic ready;     // tag sweep done
  logic issue_ok;  // response credit available

  l2c_req_if    req_bus ();
  l2c_access_if acc_bus ();
  l2c_result_if res_bus ();

  l2c_req_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_req_queue (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_op      (req_op),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_byte_en (req_byte_en),
    .ready       (ready),
    .issue_ok    (issue_ok),
    .req_credit  (req_credit),
    .req         (req_bus)
  );

  l2c_tag_lru i_tag_lru (
    .clk   (clk),
    .rst   (rst),
    .req   (req_bus),
    .ready (ready),
    .acc   (acc_bus)
  );

  l2c_data_banks i_data_banks (
    .clk (clk),
    .acc (acc_bus),
    .res (res_bus)
  );

  l2c_rsp_stage #(
    .RSP_CREDITS (RSP_CREDITS)
  ) i_rsp_stage (
    .clk        (clk),
    .rst        (rst),
    .rsp_credit (rsp_credit),
    .res        (res_bus),
    .issue      (req_credit),  // every pop is one issue
    .issue_ok   (issue_ok),
    .rsp_valid  (rsp_valid),
    .rsp_op     (rsp_op),
    .rsp_hit    (rsp_hit),
    .rsp_rdata  (rsp_rdata)
  );

endmodule

`default_nettype wire

/* test/l2c_model.svh */
`ifndef L2C_MODEL_SVH
`define L2C_MODEL_SVH

// reference cache state per set and way
tag_t  m_tag  [NUM_SETS][NUM_WAYS];
logic  m_vld  [NUM_SETS][NUM_WAYS];
age_t  m_age  [NUM_SETS][NUM_WAYS];
word_t m_data [NUM_SETS][NUM_WAYS][WORDS_PER_LINE];

function automatic void model_reset();
  for (int s = 0; s < NUM_SETS; s++) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      m_vld[s][w] = 1'b0;
      m_age[s][w] = age_t'(w);  // swept sets start in way order
    end
  end
endfunction

// predicts one response, then applies the request
function automatic void model_access(input l2c_op_e op, input addr_t addr, input line_t wdata,
                                     input byte_en_t be, output logic hit, output word_t rdata);
  tag_t t;
  int   s;
  int   o;
  int   way;
  age_t old;
  t     = addr[15:8];
  s     = int'(addr[7:2]);
  o     = int'(addr[1:0]);
  rdata = '0;
  way   = -1;
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (m_vld[s][w] && m_tag[s][w] == t) way = w;
  end
  hit = (way >= 0);
  if (op == op_insert && !hit) begin
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (m_age[s][w] == 2'd3) way = w;  // oldest
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!m_vld[s][w]) way = w;         // lowest free way wins
    end
  end
  if (way < 0) return;  // read or write miss
  if (op == op_read) rdata = m_data[s][way][o];
  if (op == op_write) begin
    for (int i = 0; i < 4; i++) begin
      if (be[i]) m_data[s][way][o][8*i +: 8] = wdata[32*o + 8*i +: 8];
    end
  end
  if (op == op_insert) begin
    m_tag[s][way] = t;
    m_vld[s][way] = 1'b1;
    for (int k = 0; k < WORDS_PER_LINE; k++) m_data[s][way][k] = wdata[32*k +: 32];
  end
  old = m_age[s][way];
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (m_age[s][w] < old) m_age[s][w] = m_age[s][w] + age_t'(1);
  end
  m_age[s][way] = '0;
endfunction

`endif

/* test/l2c_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module l2c_tb;
  import l2c_geom_pkg::*;
  import l2c_txn_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  localparam int RSP_CREDITS = 4;
  localparam int WAIT_LIMIT  = 400;

  logic     clk;
  logic     rst;
  logic     req_valid;
  l2c_op_e  req_op;
  addr_t    req_addr;
  line_t    req_wdata;
  byte_en_t req_byte_en;
  logic     req_credit;
  logic     rsp_credit;
  logic     rsp_valid;
  l2c_op_e  rsp_op;
  logic     rsp_hit;
  word_t    rsp_rdata;

  int req_sent        = 0;  // driver side
  int rsp_returned    = 0;
  int req_credit_seen = 0;  // monitor side
  int rsp_seen        = 0;
  bit hold            = 1'b0;  // keep response credits back

  l2c_op_e exp_op[$];
  logic    exp_hit[$];
  word_t   exp_rdata[$];

  `include "l2c_model.svh"

  l2c_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .RSP_CREDITS (RSP_CREDITS)
  ) i_l2c_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic value_error(string what);
    abort_run($sformatf("Error at %0t ns: %s", $time, what));
  endtask

  // one falling edge; a response credit goes back unless held
  task automatic step();
    @(negedge clk);
    req_valid  = 1'b0;
    rsp_credit = !hold && (rsp_seen > rsp_returned);
    if (rsp_credit) rsp_returned++;
  endtask

  task automatic send(l2c_op_e op, addr_t addr, line_t wdata, byte_en_t be);
    int    waited = 0;
    logic  hit;
    word_t rdata;
    step();
    while (req_sent - req_credit_seen >= QUEUE_DEPTH) begin
      if (waited == WAIT_LIMIT) abort_run("timed out waiting for a request credit");
      waited++;
      step();
    end
    req_valid   = 1'b1;
    req_op      = op;
    req_addr    = addr;
    req_wdata   = wdata;
    req_byte_en = be;
    req_sent++;
    model_access(op, addr, wdata, be, hit, rdata);
    exp_op.push_back(op);
    exp_hit.push_back(hit);
    exp_rdata.push_back(rdata);
  endtask

  task automatic wait_responses(int target);
    int waited = 0;
    while (rsp_seen < target || (!hold && rsp_returned < rsp_seen)) begin
      if (waited == WAIT_LIMIT) abort_run("timed out waiting for responses");
      waited++;
      step();
    end
  endtask

  function automatic addr_t make_addr(tag_t t, index_t s, offset_t o);
    return {t, s, o};
  endfunction

  function automatic line_t rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic read_word(addr_t a);
    send(op_read, a, '0, '0);
  endtask

  task automatic write_word(addr_t a, word_t d, byte_en_t be);
    line_t l = '0;
    l[32*int'(a[1:0]) +: 32] = d;  // lane of the offset
    send(op_write, a, l, be);
  endtask

  task automatic insert_line(addr_t a, line_t l);
    send(op_insert, a, l, byte_en_t'($urandom));  // insert ignores byte enables
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (req_credit) req_credit_seen++;
      if (rsp_valid) begin
        if (exp_op.size() == 0) abort_run("response arrived with no request outstanding");
        assert (rsp_op == exp_op[0])
          else value_error($sformatf("rsp %0d op %0d, expected %0d", rsp_seen, rsp_op, exp_op[0]));
        assert (rsp_hit == exp_hit[0])
          else value_error($sformatf("rsp %0d hit %0b, expected %0b", rsp_seen, rsp_hit,
                                     exp_hit[0]));
        assert (rsp_rdata == exp_rdata[0])
          else value_error($sformatf("rsp %0d rdata %h, expected %h", rsp_seen, rsp_rdata,
                                     exp_rdata[0]));
        void'(exp_op.pop_front());
        void'(exp_hit.pop_front());
        void'(exp_rdata.pop_front());
        rsp_seen++;
      end
      assert (req_credit_seen <= req_sent && req_sent - req_credit_seen <= QUEUE_DEPTH)
        else value_error("outstanding requests out of range");
      assert (rsp_seen - rsp_returned <= RSP_CREDITS)
        else value_error("more responses than response credits");
    end
  end

  initial begin
    tag_t  t;
    addr_t a;
    void'($urandom(32'h726e9ee4));
    rst         = 1'b1;
    req_valid   = 1'b0;
    req_op      = op_read;
    req_addr    = '0;
    req_wdata   = '0;
    req_byte_en = '0;
    rsp_credit  = 1'b0;
    model_reset();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // empty cache reads queue up behind the sweep
    for (int i = 0; i < 8; i++) read_word(addr_t'($urandom));
    // insert, read back, byte merge
    insert_line(make_addr(8'h12, 6'd5, 2'd0), rand_line());
    for (int o = 0; o < WORDS_PER_LINE; o++) read_word(make_addr(8'h12, 6'd5, offset_t'(o)));
    write_word(make_addr(8'h12, 6'd5, 2'd2), 32'hdead_beef, 4'b0101);
    read_word(make_addr(8'h12, 6'd5, 2'd2));
    // write miss does not allocate; insert over a resident tag
    write_word(make_addr(8'h34, 6'd5, 2'd1), 32'hcafe_f00d, 4'hf);
    read_word(make_addr(8'h34, 6'd5, 2'd1));
    insert_line(make_addr(8'h12, 6'd5, 2'd0), rand_line());
    for (int o = 0; o < WORDS_PER_LINE; o++) read_word(make_addr(8'h12, 6'd5, offset_t'(o)));
    // replacement in set 9 leaves tag 62 oldest
    for (int k = 0; k < 4; k++) insert_line(make_addr(tag_t'(8'h60 + k), 6'd9, 2'd0), rand_line());
    read_word(make_addr(8'h61, 6'd9, 2'd0));
    read_word(make_addr(8'h60, 6'd9, 2'd0));
    insert_line(make_addr(8'h64, 6'd9, 2'd0), rand_line());
    for (int k = 0; k < 5; k++) read_word(make_addr(tag_t'(8'h60 + k), 6'd9, 2'd3));
    wait_responses(req_sent);

    hold = 1'b1;
    for (int i = 0; i < QUEUE_DEPTH + RSP_CREDITS; i++) begin
      read_word(make_addr(tag_t'(8'h60 + i), 6'd9, 2'd1));
    end
    wait_responses(req_sent - QUEUE_DEPTH);
    repeat (10) step();  // stall window
    assert (rsp_seen - rsp_returned == RSP_CREDITS)
      else value_error("responses continued without credits");
    assert (req_sent - req_credit_seen == QUEUE_DEPTH)
      else value_error("queue did not hold the stalled requests");
    hold = 1'b0;
    wait_responses(req_sent);

    for (int i = 0; i < 300; i++) begin
      t = tag_t'(8'h40 + $urandom_range(0, 5));
      a = make_addr(t, index_t'(20 + $urandom_range(0, 1)), offset_t'($urandom_range(0, 3)));
      case ($urandom_range(0, 2))
        0: read_word(a);
        1: write_word(a, $urandom, byte_en_t'($urandom));
        default: insert_line(a, rand_line());
      endcase
    end
    wait_responses(req_sent);
    assert (req_credit_seen == req_sent)
      else value_error("req_credit pulses differ from requests sent");
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+test
logic/l2c_geom_pkg.sv
logic/l2c_txn_pkg.sv
logic/l2c_ifs.sv
logic/l2c_req_queue.sv
logic/l2c_tag_lru.sv
logic/l2c_data_banks.sv
logic/l2c_rsp_stage.sv
logic/l2c_top.sv
test/l2c_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= l2c_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard test/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
